//--- src.f
hw/evp_pkg.sv
hw/evp_sync_ram.sv
hw/evp_sequencer.sv
hw/evp_top.sv
verification/evp_clk_gen.sv
verification/evp_tb.sv

//--- Bender.yml
package:
  name: evp

sources:
  - hw/evp_pkg.sv
  - hw/evp_sync_ram.sv
  - hw/evp_sequencer.sv
  - hw/evp_top.sv
  - target: test
    files:
      - verification/evp_clk_gen.sv
      - verification/evp_tb.sv

//--- verification/evp_tb.sv
`timescale 1ns/1ns

module evp_tb;

	import evp_pkg::*;

	logic clk;
	logic rst;
	logic [buf_addr_w-1:0] wr_addr;
	logic [sample_w-1:0] wr_data;
	logic wr_sample;
	logic wr_coeff;
	logic wr_degree;
	logic start;
	logic [sel_w-1:0] poly_sel;
	logic [buf_addr_w-1:0] x_addr;
	logic done;
	logic [acc_w-1:0] result;
	logic [acc_w-1:0] status;
	logic [buf_addr_w-1:0] next_x_addr;

	integer seed;
	int directed_evals;
	int rand_evals;

	// model copies of what the host has written.
	logic [sample_w-1:0] coeff_mem [coeff_depth];
	logic [degree_w-1:0] degree_mem [poly_count];

	logic [acc_w-1:0] exp_result;
	logic [acc_w-1:0] exp_status;
	logic [buf_addr_w-1:0] exp_next;
	logic running; // an accepted start has no done yet.
	logic holding; // outputs must stay put until the next start.

	evp_clk_gen i_clk_gen (
		.clk(clk)
	);

	evp_top i_dut (
		.clk(clk),
		.rst(rst),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_sample(wr_sample),
		.wr_coeff(wr_coeff),
		.wr_degree(wr_degree),
		.start(start),
		.poly_sel(poly_sel),
		.x_addr(x_addr),
		.done(done),
		.result(result),
		.status(status),
		.next_x_addr(next_x_addr)
	);

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Something failed");
		$fatal(1, "run stopped at the first error");
	endtask

	function automatic logic [31:0] next_random();
		return $random(seed);
	endfunction

	task automatic step_clock();
		@(posedge clk);
		#1;
	endtask

	// strobes is {wr_degree, wr_coeff, wr_sample}.
	task automatic write_mem(input logic [2:0] strobes, input int addr, input logic [15:0] data);
		wr_addr = buf_addr_w'(addr);
		wr_data = data;
		{wr_degree, wr_coeff, wr_sample} = strobes;
		step_clock();
		{wr_degree, wr_coeff, wr_sample} = 3'b000;
	endtask

	task automatic load_poly(input int sel, input int deg, input bit big);
		logic [15:0] c;
		for (int i = 0; i < coeffs_per_poly; i++)
		begin
			c = big ? (16'h8000 | next_random()) : next_random();
			coeff_mem[sel * coeffs_per_poly + i] = c;
			write_mem(3'b010, sel * coeffs_per_poly + i, c);
		end
		degree_mem[sel] = degree_w'(deg);
		write_mem(3'b100, sel, 16'(deg));
	endtask

	// Horner form, wrapping at 32 bits.
	function automatic logic [31:0] poly_value(input int sel, input logic [15:0] xs);
		logic [31:0] acc;
		acc = '0;
		for (int i = int'(degree_mem[sel]); i >= 0; i--)
		begin
			acc = acc * xs + coeff_mem[sel * coeffs_per_poly + i];
		end
		return acc;
	endfunction

	task automatic wait_done();
		do
		begin
			@(negedge clk);
		end
		while (!done);
		step_clock();
	endtask

	task automatic run_eval(input int sel, input logic [buf_addr_w-1:0] x, input bit big,
			input bit extra_start);
		logic [15:0] xs;
		xs = big ? (16'hc000 | next_random()) : next_random();
		write_mem(3'b001, x, xs);
		if (degree_mem[sel] > max_degree)
		begin
			exp_result = '0;
			exp_status = status_bad_degree; // next_x_addr keeps its old value.
		end
		else
		begin
			exp_result = poly_value(sel, xs);
			exp_status = status_ok;
			exp_next = x + 1'b1;
		end
		holding = 1'b0;
		running = 1'b1;
		start = 1'b1;
		poly_sel = sel_w'(sel);
		x_addr = x;
		step_clock();
		start = 1'b0;
		if (extra_start)
		begin
			repeat (2) step_clock();
			start = 1'b1; // this one lands while busy and must be dropped.
			poly_sel = sel_w'(sel + 1);
			x_addr = x + 10'd5;
			step_clock();
			start = 1'b0;
		end
		wait_done();
		running = 1'b0;
		holding = 1'b1;
		repeat (3) step_clock();
	endtask

	assert property (@(posedge clk) disable iff (!rst) (done || holding) |-> result == exp_result)
	else stop_on_error($sformatf("Fail result expected %h got %h",
		$sampled(exp_result), $sampled(result)));

	assert property (@(posedge clk) disable iff (!rst) (done || holding) |-> status == exp_status)
	else stop_on_error($sformatf("Fail status expected %h got %h",
		$sampled(exp_status), $sampled(status)));

	assert property (@(posedge clk) disable iff (!rst) (done || holding) |-> next_x_addr == exp_next)
	else stop_on_error($sformatf("Fail next_x_addr expected %h got %h",
		$sampled(exp_next), $sampled(next_x_addr)));

	// from the cycle after st_start until done, the status reads busy.
	assert property (@(posedge clk) disable iff (!rst)
		(running && $past(running, 2) && !done) |-> status == status_busy)
	else stop_on_error($sformatf("Fail status expected %h got %h",
		status_busy, $sampled(status)));

	assert property (@(posedge clk) disable iff (!rst) done |-> running)
	else stop_on_error("done pulsed without an accepted start");

	assert property (@(posedge clk) disable iff (!rst) done |=> !done)
	else stop_on_error("done stayed high for more than one cycle");

	assert property (@(posedge clk) disable iff (!rst)
		($rose(running) && exp_status == status_bad_degree) |-> ##5 done)
	else stop_on_error("done for a rejected degree did not come five cycles after start");

	// watchdog sized from the worst case evaluation, with a factor of two.
	initial
	begin
		directed_evals = 5;
		rand_evals = 24;
		repeat ((directed_evals + rand_evals) * (6 + 3 * coeffs_per_poly + 4) * 2) @(posedge clk);
		stop_on_error("timeout, the evaluations did not finish in time");
	end

	initial
	begin
		seed = 32'he819_0d62;
		rst = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		wr_sample = 1'b0;
		wr_coeff = 1'b0;
		wr_degree = 1'b0;
		start = 1'b0;
		poly_sel = '0;
		x_addr = '0;
		exp_result = '0;
		exp_status = status_busy;
		exp_next = '0;
		running = 1'b0;
		holding = 1'b1; // covers the values right after reset.
		repeat (5) @(posedge clk);
		#1 rst = 1'b1;
		repeat (3) step_clock();

		load_poly(0, 0, 1'b0);
		run_eval(0, 10'd1022, 1'b0, 1'b0);
		load_poly(7, max_degree, 1'b1);
		run_eval(7, next_x_addr, 1'b1, 1'b0); // runs at 1023 and wraps to 0.
		load_poly(3, 11, 1'b0);
		run_eval(3, next_x_addr, 1'b0, 1'b0);
		load_poly(5, 31, 1'b0);
		run_eval(5, next_x_addr, 1'b0, 1'b0);
		load_poly(2, max_degree, 1'b1);
		run_eval(2, next_x_addr, 1'b1, 1'b1);

		for (int k = 0; k < rand_evals; k++)
		begin
			int sel;
			int deg;
			sel = next_random() & 7;
			deg = (next_random() & 32'h7fff_ffff) % coeffs_per_poly;
			load_poly(sel, deg, (k % 4) == 3);
			run_eval(sel, next_x_addr, (k % 4) == 3, (k % 5) == 2);
		end

		$display("Everything OK");
		$finish;
	end

endmodule

//--- verification/evp_clk_gen.sv
`timescale 1ns/1ns

module evp_clk_gen (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#2 clk = ~clk; // 4 ns period.
		end
	end

endmodule

//--- hw/evp_top.sv
`timescale 1ns/1ns

module evp_top (
	input logic clk,
	input logic rst,
	input logic [evp_pkg::buf_addr_w-1:0] wr_addr,
	input logic [evp_pkg::sample_w-1:0] wr_data,
	input logic wr_sample,
	input logic wr_coeff,
	input logic wr_degree,
	input logic start,
	input logic [evp_pkg::sel_w-1:0] poly_sel,
	input logic [evp_pkg::buf_addr_w-1:0] x_addr,
	output logic done,
	output logic [evp_pkg::acc_w-1:0] result,
	output logic [evp_pkg::acc_w-1:0] status,
	output logic [evp_pkg::buf_addr_w-1:0] next_x_addr
);

	import evp_pkg::*;

	logic sample_rd_en;
	logic [buf_addr_w-1:0] sample_rd_addr;
	logic [sample_w-1:0] sample;

	logic coeff_rd_en;
	logic [coeff_addr_w-1:0] coeff_rd_addr;
	logic [sample_w-1:0] coeff;

	logic degree_rd_en;
	logic [sel_w-1:0] degree_rd_addr;
	logic [degree_w-1:0] degree;

	// the host bus goes to every memory, each strobe picks one.
	evp_sync_ram #(
		.width(sample_w),
		.depth(buffer_size)
	) i_sample_ram (
		.clk(clk),
		.wr_en(wr_sample),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_en(sample_rd_en),
		.rd_addr(sample_rd_addr),
		.rd_data(sample)
	);

	evp_sync_ram #(
		.width(sample_w),
		.depth(coeff_depth)
	) i_coeff_ram (
		.clk(clk),
		.wr_en(wr_coeff),
		.wr_addr(wr_addr[coeff_addr_w-1:0]),
		.wr_data(wr_data),
		.rd_en(coeff_rd_en),
		.rd_addr(coeff_rd_addr),
		.rd_data(coeff)
	);

	evp_sync_ram #(
		.width(degree_w),
		.depth(poly_count)
	) i_degree_ram (
		.clk(clk),
		.wr_en(wr_degree),
		.wr_addr(wr_addr[sel_w-1:0]),
		.wr_data(wr_data[degree_w-1:0]), // only the low bits hold a degree.
		.rd_en(degree_rd_en),
		.rd_addr(degree_rd_addr),
		.rd_data(degree)
	);

	evp_sequencer i_sequencer (
		.clk(clk),
		.rst(rst),
		.start(start),
		.poly_sel(poly_sel),
		.x_addr(x_addr),
		.sample_rd_en(sample_rd_en),
		.sample_rd_addr(sample_rd_addr),
		.sample(sample),
		.coeff_rd_en(coeff_rd_en),
		.coeff_rd_addr(coeff_rd_addr),
		.coeff(coeff),
		.degree_rd_en(degree_rd_en),
		.degree_rd_addr(degree_rd_addr),
		.degree(degree),
		.next_x_addr(next_x_addr),
		.done(done),
		.result(result),
		.status(status)
	);

endmodule

//--- hw/evp_sequencer.sv
`timescale 1ns/1ns

module evp_sequencer (
	input logic clk,
	input logic rst,
	input logic start,
	input logic [evp_pkg::sel_w-1:0] poly_sel,
	input logic [evp_pkg::buf_addr_w-1:0] x_addr,
	output logic sample_rd_en,
	output logic [evp_pkg::buf_addr_w-1:0] sample_rd_addr,
	input logic [evp_pkg::sample_w-1:0] sample,
	output logic coeff_rd_en,
	output logic [evp_pkg::coeff_addr_w-1:0] coeff_rd_addr,
	input logic [evp_pkg::sample_w-1:0] coeff,
	output logic degree_rd_en,
	output logic [evp_pkg::sel_w-1:0] degree_rd_addr,
	input logic [evp_pkg::degree_w-1:0] degree,
	output logic [evp_pkg::buf_addr_w-1:0] next_x_addr,
	output logic done,
	output logic [evp_pkg::acc_w-1:0] result,
	output logic [evp_pkg::acc_w-1:0] status
);

	import evp_pkg::*;

	evp_state_t state;
	evp_state_t state_nxt;

	logic [sel_w-1:0] sel_q;
	logic [buf_addr_w-1:0] x_addr_q;
	logic [$clog2(coeffs_per_poly + 1)-1:0] term_idx; // index of the next coefficient to read.

	logic [sample_w-1:0] x_val;
	logic [sample_w-1:0] c_val;
	logic [acc_w-1:0] monomial;
	logic [acc_w-1:0] sum;

	logic term_last;
	logic degree_bad;

	// the degree table keeps its read value, so the degree needs no local copy.
	assign degree_bad = degree > degree_w'(max_degree);
	assign term_last = degree_w'(term_idx) > degree;

	// memory read ports
	assign degree_rd_en = (state == st_rd_degree);
	assign degree_rd_addr = sel_q;
	assign sample_rd_en = (state == st_rd_sample);
	assign sample_rd_addr = x_addr_q;
	assign coeff_rd_en = (state == st_rd_sample) || (state == st_fetch_coeff);
	assign coeff_rd_addr = coeff_addr_w'(sel_q * coeffs_per_poly) + coeff_addr_w'(term_idx);

	assign done = (state == st_end);

	always_comb
	begin
		state_nxt = state;
		case (state)
			st_idle:
			begin
				if (start)
				begin
					state_nxt = st_start;
				end
			end
			st_start:
			begin
				state_nxt = st_rd_degree;
			end
			st_rd_degree:
			begin
				state_nxt = st_check_degree;
			end
			st_check_degree:
			begin
				if (degree_bad)
				begin
					state_nxt = st_error;
				end
				else
				begin
					state_nxt = st_rd_sample;
				end
			end
			st_rd_sample:
			begin
				state_nxt = st_capture;
			end
			st_capture:
			begin
				state_nxt = st_mac;
			end
			st_mac:
			begin
				if (term_last)
				begin
					state_nxt = st_output;
				end
				else
				begin
					state_nxt = st_fetch_coeff;
				end
			end
			st_fetch_coeff:
			begin
				state_nxt = st_next_term;
			end
			st_next_term:
			begin
				state_nxt = st_mac;
			end
			st_output:
			begin
				state_nxt = st_end;
			end
			st_error:
			begin
				state_nxt = st_end;
			end
			st_end:
			begin
				state_nxt = st_idle;
			end
			default:
			begin
				state_nxt = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= st_idle;
			sel_q <= '0;
			x_addr_q <= '0;
			term_idx <= '0;
			next_x_addr <= '0;
			result <= '0;
			status <= status_busy;
		end
		else
		begin
			state <= state_nxt;
			case (state)
				st_idle:
				begin
					if (start)
					begin
						sel_q <= poly_sel; // start is only looked at here.
						x_addr_q <= x_addr;
					end
				end
				st_start:
				begin
					term_idx <= '0;
					result <= '0;
					status <= status_busy;
				end
				st_rd_sample:
				begin
					next_x_addr <= x_addr_q + 1'b1; // wraps at the end of the buffer.
				end
				st_capture:
				begin
					term_idx <= 1'b1; // c0 is already on its way in.
				end
				st_next_term:
				begin
					term_idx <= term_idx + 1'b1;
				end
				st_output:
				begin
					result <= sum;
					status <= status_ok;
				end
				st_error:
				begin
					result <= '0;
					status <= status_bad_degree;
				end
				default:
				begin
				end
			endcase
		end
	end

	// arithmetic registers, all set up in st_capture before they are used.
	always_ff @(posedge clk)
	begin
		case (state)
			st_capture:
			begin
				x_val <= sample;
				c_val <= coeff;
				monomial <= acc_w'(1);
				sum <= '0;
			end
			st_mac:
			begin
				sum <= sum + monomial * acc_w'(c_val); // low 32 bits only.
			end
			st_next_term:
			begin
				c_val <= coeff;
				monomial <= monomial * acc_w'(x_val);
			end
			default:
			begin
			end
		endcase
	end

endmodule

//--- hw/evp_sync_ram.sv
`timescale 1ns/1ns

module evp_sync_ram #(
	parameter int width = 16,
	parameter int depth = 1024
) (
	input logic clk,
	input logic wr_en,
	input logic [$clog2(depth)-1:0] wr_addr,
	input logic [width-1:0] wr_data,
	input logic rd_en,
	input logic [$clog2(depth)-1:0] rd_addr,
	output logic [width-1:0] rd_data
);

	logic [width-1:0] mem [depth];

	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			mem[wr_addr] <= wr_data;
		end
	end

	// the read register only moves on rd_en, so a value stays put between reads.
	always_ff @(posedge clk)
	begin
		if (rd_en)
		begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

//--- hw/evp_pkg.sv
package evp_pkg;

	// data buffer
	localparam int buffer_size = 1024;
	localparam int buf_addr_w = $clog2(buffer_size); // 10 bits.

	// datapath widths
	localparam int sample_w = 16; // samples and coefficients share this width.
	localparam int acc_w = 32;

	// coefficient store and degree table
	localparam int poly_count = 8;
	localparam int sel_w = $clog2(poly_count);
	localparam int coeffs_per_poly = 11; // c0 up to c10.
	localparam int max_degree = coeffs_per_poly - 1;
	localparam int coeff_depth = poly_count * coeffs_per_poly; // 88 words.
	localparam int coeff_addr_w = $clog2(coeff_depth);
	localparam int degree_w = 5;

	// status codes reported next to the result
	localparam logic [acc_w-1:0] status_ok = '0;
	localparam logic [acc_w-1:0] status_bad_degree = acc_w'(2);
	localparam logic [acc_w-1:0] status_busy = '1; // held from reset and while running.

	typedef enum logic [3:0] {
		st_idle,
		st_start,
		st_rd_degree,
		st_check_degree,
		st_rd_sample,
		st_capture,
		st_mac,
		st_fetch_coeff,
		st_next_term,
		st_output,
		st_error,
		st_end
	} evp_state_t;

endpackage
